// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Instruction and PC width in bits.
`define FETCH_XLEN 32

// One cache line carries four instructions.
`define FETCH_LINE_BITS 128
`define FETCH_IFQ_DEPTH 4
`define FETCH_ICACHE_LINES 8
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // Major opcode in the top six bits of every instruction.
   typedef enum logic [5:0] {
      op_nop     = 6'h00,
      op_alu     = 6'h01,
      op_load    = 6'h02,
      op_store   = 6'h03,
      op_jump    = 6'h04,
      op_illegal = 6'h3f
   } opcode_e;

   localparam int unsigned OPCODE_MSB = 31;
   localparam int unsigned OPCODE_LSB = 26;
   // A jump holds a signed word offset below the opcode.
   localparam int unsigned JUMP_OFFSET_BITS = 26;

endpackage

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

   typedef logic [`FETCH_XLEN-1:0] word_t;
   typedef logic [`FETCH_LINE_BITS-1:0] line_t;

   // Cache controller states.
   // st_lookup compares the tag of the accepted address.
   // st_refill waits for the memory line of a miss.
   // st_drop does the same for a request the queue has given up on.
   typedef enum logic [1:0] {
      st_idle,
      st_lookup,
      st_refill,
      st_drop
   } icache_state_e;

endpackage

`default_nettype wire

// ==== source/ifq.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module ifq
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   // Cache side.
   output word_t icache_pcin,
   output logic  icache_ren,
   output logic  icache_abort,
   input  logic  icache_ready,
   input  line_t icache_dout,
   input  logic  icache_dout_valid,
   // Dispatch side.
   output word_t dispatch_pcout_plus4,
   output word_t dispatch_inst,
   output logic  dispatch_empty,
   input  logic  dispatch_ren,
   input  logic  dispatch_branch_valid,
   input  word_t dispatch_branch_addr
);

   localparam word_t RESET_PC = `FETCH_RESET_PC;

   line_t      store_q [`FETCH_IFQ_DEPTH];
   line_t      head_line;
   logic [4:0] wptr_q;
   logic [4:0] wptr_d;
   logic [4:0] rptr_q;
   logic [4:0] rptr_d;
   word_t      pcin_q;
   word_t      pcin_d;
   word_t      pcout_q;
   word_t      pcout_d;
   word_t      target_line;
   word_t      target_pc;
   logic       pending_q;
   logic       pending_d;
   logic       is_empty;
   logic       is_full;
   logic       accept;
   logic       do_read;
   logic       do_write;
   logic       do_bypass;

   // Pointers count words, so bits 4:2 name a line slot plus the wrap bit.
   assign is_empty = (wptr_q[4:2] == rptr_q[4:2]);
   assign is_full  = (wptr_q[4] != rptr_q[4]) && (wptr_q[3:2] == rptr_q[3:2]);

   assign target_line = {dispatch_branch_addr[`FETCH_XLEN-1:4], 4'h0};
   assign target_pc   = {dispatch_branch_addr[`FETCH_XLEN-1:2], 2'b00};

   // Only one cache read may be outstanding at a time.
   // A redirect empties the queue, so it may issue even when full.
   assign icache_ren   = !pending_q && (!is_full || dispatch_branch_valid);
   assign icache_pcin  = dispatch_branch_valid ? target_line : pcin_q;
   assign accept       = icache_ren && icache_ready;

   // A line that lands in the redirect cycle is simply dropped, so no abort
   // is needed for it.
   assign icache_abort = dispatch_branch_valid && pending_q && !icache_dout_valid;

   // An empty queue offers the arriving line straight to dispatch.
   assign do_bypass = is_empty && pending_q && icache_dout_valid;
   assign do_write  = pending_q && icache_dout_valid && !dispatch_branch_valid;
   assign do_read   = dispatch_ren && !dispatch_empty;

   assign dispatch_empty       = is_empty && !do_bypass;
   assign head_line            = do_bypass ? icache_dout : store_q[rptr_q[3:2]];
   assign dispatch_inst        = head_line[rptr_q[1:0]*`FETCH_XLEN +: `FETCH_XLEN];
   assign dispatch_pcout_plus4 = pcout_q + 32'd4;

   always_comb begin
      pending_d = pending_q;
      if (accept) begin
         pending_d = 1'b1;
      end else if (icache_dout_valid || icache_abort) begin
         pending_d = 1'b0;
      end

      // The redirect flushes both pointers.
      // The read pointer starts at the target word inside its line.
      if (dispatch_branch_valid) begin
         rptr_d  = {3'b000, dispatch_branch_addr[3:2]};
         wptr_d  = 5'd0;
         pcout_d = target_pc;
      end else begin
         rptr_d  = do_read ? rptr_q + 5'd1 : rptr_q;
         wptr_d  = do_write ? wptr_q + 5'd4 : wptr_q;
         pcout_d = do_read ? pcout_q + 32'd4 : pcout_q;
      end

      if (accept) begin
         pcin_d = icache_pcin + 32'd16;
      end else if (dispatch_branch_valid) begin
         pcin_d = target_line;
      end else begin
         pcin_d = pcin_q;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending_q <= 1'b0;
         wptr_q    <= 5'd0;
         rptr_q    <= {3'b000, RESET_PC[3:2]};
         pcin_q    <= {RESET_PC[`FETCH_XLEN-1:4], 4'h0};
         pcout_q   <= RESET_PC;
      end else begin
         pending_q <= pending_d;
         wptr_q    <= wptr_d;
         rptr_q    <= rptr_d;
         pcin_q    <= pcin_d;
         pcout_q   <= pcout_d;
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         store_q[wptr_q[3:2]] <= icache_dout;
      end
   end

endmodule

`default_nettype wire

// ==== source/icache.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module icache
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   // Queue side.
   input  logic  icache_ren,
   input  word_t icache_pcin,
   input  logic  icache_abort,
   output logic  icache_ready,
   output line_t icache_dout,
   output logic  icache_dout_valid,
   // Memory side.
   output logic  mem_req_valid,
   output word_t mem_req_addr,
   input  logic  mem_req_ready,
   input  logic  mem_resp_valid,
   input  line_t mem_resp_line
);

   localparam int unsigned OFF_BITS = $clog2(`FETCH_LINE_BITS / 8);
   localparam int unsigned IDX_BITS = $clog2(`FETCH_ICACHE_LINES);
   localparam int unsigned TAG_LSB  = OFF_BITS + IDX_BITS;
   localparam int unsigned TAG_BITS = $bits(word_t) - TAG_LSB;

   icache_state_e                  state_q;
   icache_state_e                  state_d;
   logic [$bits(word_t)-1:OFF_BITS] req_line_q;
   logic [IDX_BITS-1:0]            req_idx;
   logic [TAG_BITS-1:0]            req_tag;
   logic [`FETCH_ICACHE_LINES-1:0] valid_q;
   logic [TAG_BITS-1:0]            tag_q  [`FETCH_ICACHE_LINES];
   line_t                          data_q [`FETCH_ICACHE_LINES];
   logic                           hit;
   logic                           accept;
   logic                           refilling;
   logic                           fill;
   logic                           mem_sent_q;
   logic                           resp_q;

   assign req_idx   = req_line_q[TAG_LSB-1:OFF_BITS];
   assign req_tag   = req_line_q[$bits(word_t)-1:TAG_LSB];
   assign hit       = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
   assign accept    = icache_ren && icache_ready;
   assign refilling = (state_q == st_refill) || (state_q == st_drop);
   assign fill      = refilling && mem_resp_valid;

   assign icache_ready = (state_q == st_idle);

   // The line is read from the array in both the hit and the refill case.
   // After a refill the addressed entry already holds the new line.
   assign icache_dout       = data_q[req_idx];
   assign icache_dout_valid = ((state_q == st_lookup) && hit) || resp_q;

   // The request is raised straight from the lookup on a miss and held
   // until memory takes it.
   assign mem_req_valid = ((state_q == st_lookup) && !hit) || (refilling && !mem_sent_q);
   assign mem_req_addr  = {req_line_q, {OFF_BITS{1'b0}}};

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (accept) state_d = st_lookup;
         end
         st_lookup: begin
            if (hit) begin
               state_d = st_idle;
            end else if (icache_abort) begin
               state_d = st_drop;
            end else begin
               state_d = st_refill;
            end
         end
         st_refill: begin
            if (fill) begin
               state_d = st_idle;
            end else if (icache_abort) begin
               state_d = st_drop;
            end
         end
         st_drop: begin
            if (fill) state_d = st_idle;
         end
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= st_idle;
         valid_q    <= '0;
         mem_sent_q <= 1'b0;
         resp_q     <= 1'b0;
      end else begin
         state_q <= state_d;
         // An abort in the same cycle as the response still fills the line.
         resp_q  <= fill && (state_q == st_refill) && !icache_abort;
         if (state_q == st_lookup) begin
            mem_sent_q <= mem_req_valid && mem_req_ready;
         end else if (mem_req_valid && mem_req_ready) begin
            mem_sent_q <= 1'b1;
         end
         if (fill) valid_q[req_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_line_q <= icache_pcin[$bits(word_t)-1:OFF_BITS];
      end
      if (fill) begin
         data_q[req_idx] <= mem_resp_line;
         tag_q[req_idx]  <= req_tag;
      end
   end

endmodule

`default_nettype wire

// ==== source/dispatch_decode.sv ====
`default_nettype none
`timescale 1ns/1ns

module dispatch_decode
   import isa_pkg::*, fetch_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   // Queue side.
   input  word_t   dispatch_inst,
   input  word_t   dispatch_pcout_plus4,
   input  logic    dispatch_empty,
   output logic    dispatch_ren,
   output logic    dispatch_branch_valid,
   output word_t   dispatch_branch_addr,
   // Decoded instruction output.
   output logic    out_valid,
   output word_t   out_inst,
   output opcode_e out_opcode,
   output word_t   out_pc_plus4,
   input  logic    out_ready
);

   localparam int unsigned EXT_BITS = $bits(word_t) - JUMP_OFFSET_BITS - 2;

   opcode_e dec_op;
   logic    take;
   word_t   jump_disp;

   always_comb begin
      case (opcode_e'(dispatch_inst[OPCODE_MSB:OPCODE_LSB]))
         op_alu, op_load, op_store, op_jump, op_nop: begin
            dec_op = opcode_e'(dispatch_inst[OPCODE_MSB:OPCODE_LSB]);
         end
         default: dec_op = op_illegal;
      endcase
   end

   // The output register takes a new instruction when it is free or
   // being drained this cycle.
   assign dispatch_ren = !out_valid || out_ready;
   assign take         = dispatch_ren && !dispatch_empty;

   // Jump target is PC plus 4 plus the sign-extended word offset.
   assign jump_disp = {{EXT_BITS{dispatch_inst[JUMP_OFFSET_BITS-1]}},
                       dispatch_inst[JUMP_OFFSET_BITS-1:0], 2'b00};
   assign dispatch_branch_addr  = dispatch_pcout_plus4 + jump_disp;
   assign dispatch_branch_valid = take && (dec_op == op_jump);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_inst     <= dispatch_inst;
         out_opcode   <= dec_op;
         out_pc_plus4 <= dispatch_pcout_plus4;
      end
   end

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module fetch_top
   import isa_pkg::*, fetch_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   // Instruction memory.
   output logic    mem_req_valid,
   output word_t   mem_req_addr,
   input  logic    mem_req_ready,
   input  logic    mem_resp_valid,
   input  line_t   mem_resp_line,
   // Decoded instruction stream.
   output logic    out_valid,
   output word_t   out_inst,
   output opcode_e out_opcode,
   output word_t   out_pc_plus4,
   input  logic    out_ready
);

   word_t icache_pcin;
   logic  icache_ren;
   logic  icache_abort;
   logic  icache_ready;
   line_t icache_dout;
   logic  icache_dout_valid;
   word_t dispatch_pcout_plus4;
   word_t dispatch_inst;
   logic  dispatch_empty;
   logic  dispatch_ren;
   logic  dispatch_branch_valid;
   word_t dispatch_branch_addr;

   ifq u_ifq (
      .clk                  (clk),
      .arst_n               (arst_n),
      .icache_pcin          (icache_pcin),
      .icache_ren           (icache_ren),
      .icache_abort         (icache_abort),
      .icache_ready         (icache_ready),
      .icache_dout          (icache_dout),
      .icache_dout_valid    (icache_dout_valid),
      .dispatch_pcout_plus4 (dispatch_pcout_plus4),
      .dispatch_inst        (dispatch_inst),
      .dispatch_empty       (dispatch_empty),
      .dispatch_ren         (dispatch_ren),
      .dispatch_branch_valid(dispatch_branch_valid),
      .dispatch_branch_addr (dispatch_branch_addr)
   );

   icache u_icache (
      .clk              (clk),
      .arst_n           (arst_n),
      .icache_ren       (icache_ren),
      .icache_pcin      (icache_pcin),
      .icache_abort     (icache_abort),
      .icache_ready     (icache_ready),
      .icache_dout      (icache_dout),
      .icache_dout_valid(icache_dout_valid),
      .mem_req_valid    (mem_req_valid),
      .mem_req_addr     (mem_req_addr),
      .mem_req_ready    (mem_req_ready),
      .mem_resp_valid   (mem_resp_valid),
      .mem_resp_line    (mem_resp_line)
   );

   dispatch_decode u_dispatch (
      .clk                  (clk),
      .arst_n               (arst_n),
      .dispatch_inst        (dispatch_inst),
      .dispatch_pcout_plus4 (dispatch_pcout_plus4),
      .dispatch_empty       (dispatch_empty),
      .dispatch_ren         (dispatch_ren),
      .dispatch_branch_valid(dispatch_branch_valid),
      .dispatch_branch_addr (dispatch_branch_addr),
      .out_valid            (out_valid),
      .out_inst             (out_inst),
      .out_opcode           (out_opcode),
      .out_pc_plus4         (out_pc_plus4),
      .out_ready            (out_ready)
   );

endmodule

`default_nettype wire

// ==== bench/fetch_sva.sv ====
`default_nettype none
`timescale 1ns/1ns

module fetch_sva
   import isa_pkg::*, fetch_pkg::*;
(
   input logic    clk,
   input logic    arst_n,
   input logic    out_valid,
   input logic    out_ready,
   input word_t   out_inst,
   input opcode_e out_opcode,
   input word_t   out_pc_plus4,
   input logic    mem_req_valid,
   input logic    mem_req_ready,
   input word_t   mem_req_addr,
   input logic    icache_ren,
   input logic    icache_ready,
   input logic    icache_abort,
   input logic    icache_dout_valid
);

   int   fail_count = 0;
   logic read_open;

   // A cache read is open from its acceptance until its data or its abort.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         read_open <= 1'b0;
      end else if (icache_ren && icache_ready) begin
         read_open <= 1'b1;
      end else if (icache_dout_valid || icache_abort) begin
         read_open <= 1'b0;
      end
   end

   out_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_inst)
         && $stable(out_opcode) && $stable(out_pc_plus4))
      else begin
         fail_count++;
         $error("Output changed while stalled");
      end

   mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
      else begin
         fail_count++;
         $error("Memory request dropped or changed while stalled");
      end

   one_read: assert property (@(posedge clk) disable iff (!arst_n)
      read_open |-> !(icache_ren && icache_ready))
      else begin
         fail_count++;
         $error("Cache read accepted while another read was open");
      end

   owed_data: assert property (@(posedge clk) disable iff (!arst_n)
      icache_dout_valid |-> read_open)
      else begin
         fail_count++;
         $error("Cache data arrived with no open read");
      end

   reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high during reset");
      end

endmodule

bind fetch_top fetch_sva u_sva (
   .clk              (clk),
   .arst_n           (arst_n),
   .out_valid        (out_valid),
   .out_ready        (out_ready),
   .out_inst         (out_inst),
   .out_opcode       (out_opcode),
   .out_pc_plus4     (out_pc_plus4),
   .mem_req_valid    (mem_req_valid),
   .mem_req_ready    (mem_req_ready),
   .mem_req_addr     (mem_req_addr),
   .icache_ren       (icache_ren),
   .icache_ready     (icache_ready),
   .icache_abort     (icache_abort),
   .icache_dout_valid(icache_dout_valid)
);

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_tb
   import isa_pkg::*, fetch_pkg::*;
();

   // The program is a loop inside the first four lines, with one jump into the
   // middle of a line and one jump back.
   localparam word_t JUMP_A_PC  = 32'h0000_001c;
   localparam word_t JUMP_A_TGT = 32'h0000_0028;
   localparam word_t JUMP_B_PC  = 32'h0000_0038;
   localparam word_t JUMP_B_TGT = 32'h0000_0008;

   logic        clk;
   logic        arst_n;
   logic        mem_req_valid;
   word_t       mem_req_addr;
   logic        mem_req_ready;
   logic        mem_resp_valid;
   line_t       mem_resp_line;
   logic        out_valid;
   word_t       out_inst;
   opcode_e     out_opcode;
   word_t       out_pc_plus4;
   logic        out_ready;

   logic [31:0] lfsr;
   bit          filled [word_t];
   word_t       exp_pc;
   word_t       mem_addr;
   logic [2:0]  mem_wait;
   logic        mem_busy;
   logic        mem_take;
   logic        stall_out;
   logic        stall_mem;
   logic        timed_out;
   int          out_count;
   int          err_count;
   int          tests_passed;
   int          tests_failed;

   fetch_top DUT (
      .clk           (clk),
      .arst_n        (arst_n),
      .mem_req_valid (mem_req_valid),
      .mem_req_addr  (mem_req_addr),
      .mem_req_ready (mem_req_ready),
      .mem_resp_valid(mem_resp_valid),
      .mem_resp_line (mem_resp_line),
      .out_valid     (out_valid),
      .out_inst      (out_inst),
      .out_opcode    (out_opcode),
      .out_pc_plus4  (out_pc_plus4),
      .out_ready     (out_ready)
   );

   // Galois LFSR with taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step for every bit taken.
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic opcode_e op_at(input word_t pc);
      return (pc == JUMP_A_PC || pc == JUMP_B_PC) ? op_jump : op_alu;
   endfunction

   // A jump holds the word distance from the next PC to its target.
   function automatic word_t inst_at(input word_t pc);
      word_t disp;
      if (op_at(pc) == op_jump) begin
         disp = ((pc == JUMP_A_PC) ? JUMP_A_TGT : JUMP_B_TGT) - pc - 32'd4;
         return {op_jump, disp[27:2]};
      end
      return {op_alu, pc[25:0] ^ {20'h0, pc[31:26]}};
   endfunction

   function automatic word_t next_pc(input word_t pc);
      word_t inst;
      inst = inst_at(pc);
      if (op_at(pc) == op_jump) begin
         return pc + 32'd4 + {{4{inst[25]}}, inst[25:0], 2'b00};
      end
      return pc + 32'd4;
   endfunction

   function automatic line_t line_at(input word_t addr);
      line_t l;
      for (int i = 0; i < 4; i++) begin
         l[32*i +: 32] = inst_at(addr + 32'(4 * i));
      end
      return l;
   endfunction

   function automatic int total_errors();
      return err_count + DUT.u_sva.fail_count;
   endfunction

   task automatic check_output();
      word_t exp_inst;
      exp_inst = inst_at(exp_pc);
      if (out_valid && out_ready) begin
         assert (out_inst == exp_inst) else begin
            $display("Mismatch out_inst: got %h, expected %h", out_inst, exp_inst);
            err_count++;
         end
         assert (out_opcode == op_at(exp_pc)) else begin
            $display("Mismatch out_opcode: got %h, expected %h", out_opcode, op_at(exp_pc));
            err_count++;
         end
         assert (out_pc_plus4 == exp_pc + 32'd4) else begin
            $display("Mismatch out_pc_plus4: got %h, expected %h", out_pc_plus4,
                     exp_pc + 32'd4);
            err_count++;
         end
         exp_pc = next_pc(exp_pc);
         out_count++;
      end
   endtask

   task automatic check_request();
      mem_take = mem_req_valid && mem_req_ready;
      if (mem_take) begin
         assert (!mem_busy) else begin
            $display("Memory request for %h came while a response was still owed",
                     mem_req_addr);
            err_count++;
         end
         assert (!filled.exists(mem_req_addr)) else begin
            $display("Line %h was requested again after it had been filled", mem_req_addr);
            err_count++;
         end
         filled[mem_req_addr] = 1'b1;
         mem_addr = mem_req_addr;
      end
   endtask

   // The memory answers each accepted request once, after a random wait.
   task automatic drive_inputs();
      mem_resp_valid = 1'b0;
      if (!arst_n) begin
         mem_busy = 1'b0;
         mem_take = 1'b0;
         exp_pc   = `FETCH_RESET_PC;
         filled.delete();
      end else if (mem_take) begin
         mem_busy = 1'b1;
         mem_wait = 3'(rand_bits(3));
         mem_take = 1'b0;
      end else if (mem_busy) begin
         if (mem_wait == 3'd0) begin
            mem_resp_valid = 1'b1;
            mem_resp_line  = line_at(mem_addr);
            mem_busy       = 1'b0;
         end else begin
            mem_wait = mem_wait - 3'd1;
         end
      end
      out_ready     = stall_out ? (rand_bits(2) != 0) : 1'b1;
      mem_req_ready = stall_mem ? (rand_bits(1) != 0) : 1'b1;
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Outputs are sampled at the falling edge, where they are settled.
   initial begin
      lfsr           = 32'h7f6b;
      out_ready      = 1'b0;
      mem_req_ready  = 1'b0;
      mem_resp_valid = 1'b0;
      mem_resp_line  = '0;
      mem_busy       = 1'b0;
      mem_take       = 1'b0;
      mem_wait       = 3'd0;
      mem_addr       = '0;
      exp_pc         = `FETCH_RESET_PC;
      out_count      = 0;
      err_count      = 0;
      forever begin
         @(negedge clk);
         if (arst_n) begin
            check_output();
            check_request();
         end
         @(posedge clk);
         #1;
         drive_inputs();
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      #1;
      arst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
   endtask

   task automatic run_test(input string name, input int count);
      int target;
      int errors_before;
      int cycles;
      target        = out_count + count;
      errors_before = total_errors();
      cycles        = 0;
      while (out_count < target && cycles < 40 * count + 100) begin
         @(posedge clk);
         cycles++;
      end
      if (out_count < target) begin
         $display("Timeout in %s: %0d of %0d outputs after %0d cycles", name,
                  count - (target - out_count), count, cycles);
         timed_out = 1'b1;
      end
      if (out_count >= target && total_errors() == errors_before) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail", name);
      end
   endtask

   initial begin
      arst_n       = 1'b0;
      stall_out    = 1'b0;
      stall_mem    = 1'b0;
      timed_out    = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      apply_reset();
      run_test("sequential fetch", 8);
      run_test("jump redirect", 16);
      run_test("cache reuse", 60);
      stall_out = 1'b1;
      stall_mem = 1'b1;
      apply_reset();
      run_test("back-pressure", 150);
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
               total_errors());
      if (timed_out || total_errors() != 0) begin
         $display("TEST FAILED");
      end else begin
         $display("TEST OK");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/isa_pkg.sv
source/fetch_pkg.sv
source/ifq.sv
source/icache.sv
source/dispatch_decode.sv
source/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module fetch_tb -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/fetch_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0
